//--- pic_ack_sequencer.sv
`timescale 1ns/10ps

module pic_ack_sequencer import pic_pkg::*; (
    input  logic             clk_in,        // Clock.
    input  logic             rst_in,        // Async reset, active high.
    input  logic             run,           // Controller is serving.
    input  mode_t            mode,          // Latched mode.
    input  logic             hit,           // Candidate is requesting.
    input  src_t             hit_src,       // Candidate source number.
    input  logic             intr_in,       // Processor ack, active low.
    input  logic [bus_w-1:0] intr_ack_bus,  // Done code and number from processor.
    output logic             scan,          // Looking for a source.
    output logic             intr_out,      // Interrupt to processor.
    output logic [bus_w-1:0] intr_bus       // Id code and number to processor.
);

    seq_state_t        state;               // Handshake state.
    src_t              cur_src;             // Source being served.
    logic [code_w-1:0] id_code;             // Code sent with the number.
    logic [code_w-1:0] done_code;           // Code expected back.
    logic              take;                // Start serving this cycle.
    logic              done_ok;             // Valid done ack this cycle.

    //////////////////////////////
    // Codes per mode
    //////////////////////////////

    always_comb begin
        if (mode == mode_poll) begin
            id_code   = code_poll_id;
            done_code = code_poll_done;
        end else begin
            id_code   = code_prio_id;
            done_code = code_prio_done;
        end
    end

    assign scan = run && (state == seq_scan);        // Only while serving.
    assign take = scan && hit;

    // Done counts only with the right code and the served number.
    assign done_ok = !intr_in && (intr_ack_bus == {done_code, cur_src});

    //////////////////////////////
    // Served source
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (take) begin
            cur_src <= hit_src;                      // Held through the handshake.
        end
    end

    //////////////////////////////
    // Handshake FSM
    //////////////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state    <= seq_scan;
            intr_out <= 1'b0;
            intr_bus <= '0;
        end else begin
            case (state)
                // Raise the interrupt as soon as a source requests.
                seq_scan: begin
                    if (take) begin
                        intr_out <= 1'b1;
                        state    <= seq_wait_ack;
                    end
                end

                // First ack. Drop the line and put out the number.
                seq_wait_ack: begin
                    if (!intr_in) begin
                        intr_out <= 1'b0;
                        intr_bus <= {id_code, cur_src};
                        state    <= seq_wait_id_ack;
                    end
                end

                // Second ack, the processor has the number.
                seq_wait_id_ack: begin
                    if (!intr_in) begin
                        state <= seq_wait_done;
                    end
                end

                // Wait for service done. A wrong ack is simply ignored.
                seq_wait_done: begin
                    if (done_ok) begin
                        state <= seq_scan;           // Back to scanning, intr_bus kept.
                    end
                end

                default: begin
                    intr_out <= 1'b0;
                    state    <= seq_scan;
                end
            endcase
        end
    end

endmodule

//--- pic_core.sv
`timescale 1ns/10ps

module pic_core import pic_pkg::*; (
    input  logic               clk_in,            // Clock.
    input  logic               rst_in,            // Async reset, active high.
    input  logic [num_src-1:0] intr_rq,           // Level request lines.
    input  mode_t              intr_mode,         // Mode command.
    input  logic [table_w-1:0] priorities_table,  // Packed priority table.
    input  logic               intr_in,           // Processor ack, active low.
    input  logic [bus_w-1:0]   intr_ack_bus,      // Done code and number.
    output logic               intr_out,          // Interrupt to processor.
    output logic [bus_w-1:0]   intr_bus           // Id code and number.
);

    logic               run;                      // Serving.
    mode_t              mode;                     // Latched mode.
    logic [table_w-1:0] prio_table;               // Held table.
    logic               scan;                     // Scan cycle.
    logic               hit;                      // Candidate requests.
    src_t               hit_src;                  // Candidate number.

    // Start-up command and table load.
    pic_mode_ctrl mode_ctrl_i (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .run              (run),
        .mode             (mode),
        .prio_table       (prio_table)
    );

    // Which source to serve.
    pic_source_select source_select_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .intr_rq    (intr_rq),
        .run        (run),
        .mode       (mode),
        .prio_table (prio_table),
        .scan       (scan),
        .hit        (hit),
        .hit_src    (hit_src)
    );

    // Processor side.
    pic_ack_sequencer ack_sequencer_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .run          (run),
        .mode         (mode),
        .hit          (hit),
        .hit_src      (hit_src),
        .intr_in      (intr_in),
        .intr_ack_bus (intr_ack_bus),
        .scan         (scan),
        .intr_out     (intr_out),
        .intr_bus     (intr_bus)
    );

endmodule

//--- pic_mode_ctrl.sv
`timescale 1ns/10ps

module pic_mode_ctrl import pic_pkg::*; (
    input  logic               clk_in,            // Clock.
    input  logic               rst_in,            // Async reset, active high.
    input  mode_t              intr_mode,         // Mode command from outside.
    input  logic [table_w-1:0] priorities_table,  // Packed priority table.
    output logic               run,               // Controller is serving.
    output mode_t              mode,              // Latched mode, valid with run.
    output logic [table_w-1:0] prio_table         // Held priority table.
);

    ctrl_state_t state;                           // Sequencer state.
    logic        mode_ok;                         // Command is poll or prio.
    logic        mode_is_prio;                    // Command asks for the table.

    //////////////////////////////
    // Command decode
    //////////////////////////////

    assign mode_ok      = (intr_mode == mode_poll) || (intr_mode == mode_prio);
    assign mode_is_prio = (intr_mode == mode_prio);

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    // One cycle of reset step, then wait for a valid mode.
    // A valid mode is latched, and the next cycle checks it again.
    // Still valid gives run at the following edge, otherwise start over.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state      <= ctrl_reset;
            run        <= 1'b0;
            mode       <= mode_none;
            prio_table <= '0;
        end else begin
            case (state)
                // Clear everything, then listen for a command.
                ctrl_reset: begin
                    run        <= 1'b0;
                    mode       <= mode_none;
                    prio_table <= '0;                       // Table empty again.
                    state      <= ctrl_wait;
                end

                // Wait here until a valid command shows up.
                ctrl_wait: begin
                    if (mode_ok) begin
                        mode  <= intr_mode;                 // Remember the mode.
                        state <= ctrl_jump;
                        if (mode_is_prio) begin
                            prio_table <= priorities_table; // Only priority mode loads.
                        end
                    end
                end

                // Jump cycle, the command must still be valid.
                ctrl_jump: begin
                    if (mode_ok) begin
                        run   <= 1'b1;                      // Start serving.
                        state <= ctrl_run;
                    end else begin
                        state <= ctrl_reset;                // Mode went bad, start over.
                    end
                end

                // Serving, only reset leaves this state.
                ctrl_run: begin
                    run <= 1'b1;
                end

                // Any other code falls back to the reset step.
                default: begin
                    run   <= 1'b0;
                    state <= ctrl_reset;
                end
            endcase
        end
    end

endmodule

//--- pic_pkg.sv
package pic_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int num_src = 8;                 // Interrupt request lines.
    localparam int src_w   = 3;                 // Bits in a source number.
    localparam int code_w  = 5;                 // Bits in a condition code.
    localparam int bus_w   = code_w + src_w;    // Code on top, source number below.
    localparam int table_w = num_src * src_w;   // Eight packed entries, entry 0 lowest.

    //////////////////////////////
    // Condition codes
    //////////////////////////////

    // Sent by the controller together with the source number.
    localparam logic [code_w-1:0] code_poll_id   = 5'b01011;
    localparam logic [code_w-1:0] code_prio_id   = 5'b10011;

    // Expected back from the processor when service is done.
    localparam logic [code_w-1:0] code_poll_done = 5'b10100;
    localparam logic [code_w-1:0] code_prio_done = 5'b01100;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [src_w-1:0] src_t;            // Source number.

    // Mode command. Only poll and prio start the controller.
    typedef enum logic [1:0] {
        mode_none = 2'b00,                      // No command yet.
        mode_poll = 2'b01,                      // Fixed order scan.
        mode_prio = 2'b10,                      // Table driven pick.
        mode_bad  = 2'b11                       // Invalid.
    } mode_t;

    // Start-up sequencer.
    typedef enum logic [1:0] {
        ctrl_reset = 2'b00,                     // Clear, then wait for a command.
        ctrl_wait  = 2'b01,                     // Sample intr_mode each cycle.
        ctrl_jump  = 2'b10,                     // Re-check the command.
        ctrl_run   = 2'b11                      // Serving until reset.
    } ctrl_state_t;

    // Processor handshake.
    typedef enum logic [1:0] {
        seq_scan        = 2'b00,                // Looking for a requesting source.
        seq_wait_ack    = 2'b01,                // intr_out high, wait for first ack.
        seq_wait_id_ack = 2'b10,                // Number on intr_bus, wait for second ack.
        seq_wait_done   = 2'b11                 // Wait for a matching done ack.
    } seq_state_t;

endpackage

//--- pic_source_select.sv
`timescale 1ns/10ps

module pic_source_select import pic_pkg::*; (
    input  logic               clk_in,       // Clock.
    input  logic               rst_in,       // Async reset, active high.
    input  logic [num_src-1:0] intr_rq,      // Level request lines.
    input  logic               run,          // Controller is serving.
    input  mode_t              mode,         // Latched mode.
    input  logic [table_w-1:0] prio_table,   // Held priority table.
    input  logic               scan,         // Sequencer is scanning.
    output logic               hit,          // Candidate is requesting now.
    output src_t               hit_src       // Candidate source number.
);

    src_t poll_idx;                          // Polling candidate.
    logic poll_hit;                          // Polling candidate requests.
    src_t prio_entry [num_src];              // Unpacked table entries.
    logic prio_hit;                          // Some table entry requests.
    src_t prio_src;                          // First requesting table entry.

    //////////////////////////////
    // Polling scan
    //////////////////////////////

    assign poll_hit = intr_rq[poll_idx];     // Look at one line per cycle.

    // Step on a scan cycle without a hit.
    // A hit holds the index, so the served source is looked at first next time.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            poll_idx <= '0;
        end else if (!run) begin
            poll_idx <= '0;                  // Start from source 0.
        end else if ((mode == mode_poll) && scan && !poll_hit) begin
            poll_idx <= poll_idx + 1'b1;     // Wraps after source 7.
        end
    end

    //////////////////////////////
    // Priority pick
    //////////////////////////////

    // Split the packed table, entry 0 in the lowest bits.
    always_comb begin
        for (int i = 0; i < num_src; i++) begin
            prio_entry[i] = prio_table[i*src_w +: src_w];
        end
    end

    // Walk from the lowest priority up, so entry 0 wins last.
    always_comb begin
        prio_hit = 1'b0;
        prio_src = '0;
        for (int i = num_src - 1; i >= 0; i--) begin
            if (intr_rq[prio_entry[i]]) begin
                prio_hit = 1'b1;
                prio_src = prio_entry[i];    // Higher entry overrides.
            end
        end
    end

    //////////////////////////////
    // Candidate out
    //////////////////////////////

    always_comb begin
        case (mode)
            mode_poll: begin
                hit     = poll_hit;
                hit_src = poll_idx;
            end
            mode_prio: begin
                hit     = prio_hit;
                hit_src = prio_src;
            end
            default: begin                   // No valid mode, nothing to offer.
                hit     = 1'b0;
                hit_src = '0;
            end
        endcase
    end

endmodule

//--- pic_tb_model.svh
`ifndef PIC_TB_MODEL_SVH
`define PIC_TB_MODEL_SVH

//////////////////////////////
// Reference model
//////////////////////////////

// First requesting line at or after the last served one, wrapping after 7.
function automatic src_t poll_pick(input logic [num_src-1:0] rq, input src_t last);
    src_t idx;
    idx = last;
    for (int k = 0; k < num_src; k++) begin
        if (rq[idx]) begin
            return idx;                         // Found the next one in order.
        end
        idx = src_t'(idx + 1);
    end
    return last;                                // Nothing requests.
endfunction

// First table entry, from entry 0 on, whose line requests.
function automatic src_t prio_pick(input logic [num_src-1:0] rq,
                                   input logic [table_w-1:0] tbl);
    src_t entry;
    for (int i = 0; i < num_src; i++) begin
        entry = tbl[i*src_w +: src_w];
        if (rq[entry]) begin
            return entry;
        end
    end
    return '0;
endfunction

//////////////////////////////
// Stimulus
//////////////////////////////

// Random table, the same source may show up in several entries.
function automatic logic [table_w-1:0] rand_table();
    logic [table_w-1:0] tbl;
    for (int i = 0; i < num_src; i++) begin
        tbl[i*src_w +: src_w] = src_t'($urandom_range(0, num_src - 1));
    end
    return tbl;
endfunction

// Never all zero; in priority mode at least one table source requests.
function automatic logic [num_src-1:0] rand_requests(input logic [table_w-1:0] tbl,
                                                     input bit use_table);
    logic [num_src-1:0] rq;
    int                 pick;
    rq = (num_src)'($urandom_range(1, (1 << num_src) - 1));
    if (use_table) begin
        pick = $urandom_range(0, num_src - 1);
        rq[tbl[pick*src_w +: src_w]] = 1'b1;    // Make sure the table gets a hit.
    end
    return rq;
endfunction

//////////////////////////////
// Compare
//////////////////////////////

task automatic check_val(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("Mismatch %s: expected 0x%0h, actual 0x%0h at %0t",
                 name, expected, actual, $time);
    end
endtask

`endif

//--- pic_tb.sv
`timescale 1ns/10ps

module pic_tb import pic_pkg::*; ();

    localparam int num_trans  = 40;                          // Interrupts per mode.
    localparam int wd_cycles  = 2 * num_trans * 200 + 400;   // Run limit in cycles.

    logic               clk_in = 1'b0;
    logic               rst_in;
    logic [num_src-1:0] intr_rq;
    mode_t              intr_mode;
    logic [table_w-1:0] priorities_table;
    logic               intr_in;                             // Active low.
    logic [bus_w-1:0]   intr_ack_bus;
    logic               intr_out;
    logic [bus_w-1:0]   intr_bus;

    int                 err_count   = 0;                     // Failed checks.
    int                 check_count = 0;                     // All checks.
    logic [table_w-1:0] tbl;                                 // Table used in priority mode.
    logic [num_src-1:0] nxt;                                 // Pattern for the next interrupt.
    src_t               exp_src;
    src_t               last;                                // Last served in polling.

    `include "pic_tb_model.svh"

    pic_core dut_i (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_rq          (intr_rq),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .intr_in          (intr_in),
        .intr_ack_bus     (intr_ack_bus),
        .intr_out         (intr_out),
        .intr_bus         (intr_bus)
    );

    always #5 clk_in = ~clk_in;                              // 10 ns period.

    // One cycle on; inputs change and outputs are read 1 ns after the edge.
    task automatic step();
        @(posedge clk_in);
        #1;
    endtask

    task automatic apply_reset();
        rst_in = 1'b1;
        repeat (10) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
    endtask

    // Processor side of one interrupt from intr_out up to the done ack.
    task automatic serve(input mode_t m, input src_t src, input logic [num_src-1:0] next_rq,
                         input bit bad_done);
        int                hold;
        logic [code_w-1:0] id_c;
        logic [code_w-1:0] done_c;
        logic [bus_w-1:0]  bad_bus;
        id_c   = (m == mode_poll) ? code_poll_id : code_prio_id;
        done_c = (m == mode_poll) ? code_poll_done : code_prio_done;
        hold   = $urandom_range(0, 20);
        while (intr_out !== 1'b1) begin
            step();
        end
        repeat (hold) begin
            step();
            check_val("intr_out", 1, intr_out);              // Held until acked.
        end
        intr_in = 1'b0;                                      // First ack.
        step();
        intr_in = 1'b1;
        check_val("intr_out", 0, intr_out);
        check_val("intr_bus", {id_c, src}, intr_bus);
        intr_rq = next_rq;                                   // New pattern once the number is taken.
        intr_in = 1'b0;                                      // Second ack.
        step();
        intr_in = 1'b1;
        if (bad_done) begin
            if ($urandom_range(0, 1) == 0) begin
                bad_bus = {id_c, src};                       // Wrong code.
            end else begin
                bad_bus = {done_c, src_t'(src + 1)};         // Wrong number.
            end
            intr_in      = 1'b0;
            intr_ack_bus = bad_bus;
            step();
            intr_in      = 1'b1;
            intr_ack_bus = '0;
            repeat (20) begin
                check_val("intr_out", 0, intr_out);          // Still waiting for done.
                step();
            end
        end
        intr_in      = 1'b0;                                 // Service done.
        intr_ack_bus = {done_c, src};
        step();
        intr_in      = 1'b1;
        intr_ack_bus = '0;
    endtask

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    initial begin
        repeat (wd_cycles) @(posedge clk_in);
        $display("Watchdog timeout: the run did not finish in time, %0d errors so far",
                 err_count);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Scenarios
    //////////////////////////////

    initial begin
        rst_in           = 1'b1;
        intr_rq          = '0;
        intr_mode        = mode_none;
        priorities_table = '0;
        intr_in          = 1'b1;
        intr_ack_bus     = '0;
        void'($urandom(24));

        // All lines requesting but no valid mode.
        intr_rq = '1;
        apply_reset();
        for (int k = 0; k < 50; k++) begin
            if (k == 25) begin
                intr_mode = mode_bad;
            end
            check_val("intr_out", 0, intr_out);
            check_val("intr_bus", 0, intr_bus);
            step();
        end
        intr_mode = mode_poll;                               // Valid for one cycle only.
        step();
        intr_mode = mode_bad;                                // Gone in the jump cycle.
        repeat (20) begin
            check_val("intr_out", 0, intr_out);
            step();
        end

        // Polling mode.
        last      = '0;
        intr_rq   = rand_requests('0, 1'b0);
        intr_mode = mode_poll;
        for (int t = 0; t < num_trans; t++) begin
            exp_src = poll_pick(intr_rq, last);
            nxt     = rand_requests('0, 1'b0);
            serve(mode_poll, exp_src, nxt, (t % 5) == 3);
            last    = exp_src;
        end

        // Priority mode after a fresh reset.
        tbl              = rand_table();
        priorities_table = tbl;
        intr_mode        = mode_prio;
        intr_rq          = rand_requests(tbl, 1'b1);
        apply_reset();
        for (int t = 0; t < num_trans; t++) begin
            exp_src = prio_pick(intr_rq, tbl);
            nxt     = rand_requests(tbl, 1'b1);
            serve(mode_prio, exp_src, nxt, (t % 5) == 2);
            if (t == 0) begin
                priorities_table = ~tbl;                     // Latched copy must stay.
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
pic_pkg.sv
pic_mode_ctrl.sv
pic_source_select.sv
pic_ack_sequencer.sv
pic_core.sv
pic_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    -f project.f --top-module pic_tb -o pic_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/pic_sim > sim.log 2>&1 \
    || { echo "Simulator returned an error, see sim.log"; }

cat sim.log

# The log decides the result.
[ -s sim.log ] || { echo "No simulation output"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
